// File: logic/mult_pkg.sv
/*
 * Shared widths and packet types for the integer multiply unit.
 * Modules refer to these by scoped name, e.g. mult_pkg::issue_pkt_t.
 */
package mult_pkg;

	localparam int XLEN      = 64;
	localparam int ROB_IDX_W = 5;
	localparam int PRF_IDX_W = 6;

	// operate format with rb as the second source
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [2:0] sbz;
		logic       lit_flag;
		logic [6:0] func;
		logic [4:0] rc;
	} inst_reg_t;

	// operate format with an 8-bit literal in place of rb
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [7:0] lit8;
		logic       lit_flag;
		logic [6:0] func;
		logic [4:0] rc;
	} inst_lit_t;

	typedef union packed {
		inst_reg_t r;
		inst_lit_t l;
	} inst_word_u;

	// one issued multiply
	typedef struct packed {
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		inst_word_u           inst;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_IDX_W-1:0] dest_tag;
	} issue_pkt_t;

	// one finished result on the common data bus
	typedef struct packed {
		logic [XLEN-1:0]      result;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_IDX_W-1:0] dest_tag;
	} cdb_pkt_t;

endpackage

// File: logic/mult_stage.sv
/*
 * One partial-product stage of the pipelined multiplier.
 * Adds one SLICE_W-bit multiplier slice times the multiplicand to the
 * running product and hands the shifted operands to the next stage.
 */
`timescale 1ns/10ps

module mult_stage #(
	parameter int SLICE_W = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        start_i,
	input  logic [63:0] product_i,
	input  logic [63:0] mplier_i,
	input  logic [63:0] mcand_i,
	output logic        done_o,
	output logic [63:0] product_o,
	output logic [63:0] mplier_o,
	output logic [63:0] mcand_o
);

	logic [63:0] prod_in_r;
	logic [63:0] partial_r;
	logic [63:0] partial;

	// low slice of the multiplier against the full multiplicand
	assign partial = mplier_i[SLICE_W-1:0] * mcand_i;

	assign product_o = prod_in_r + partial_r;

	always_ff @(posedge clock) begin
		prod_in_r <= product_i;
		partial_r <= partial;
		mplier_o  <= mplier_i >> SLICE_W;
		mcand_o   <= mcand_i << SLICE_W;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

endmodule

// File: logic/mult_pipe.sv
/*
 * Pipelined 64-bit multiplier returning the low half of the product.
 * Picks the second operand from the instruction word, runs NUM_STAGES
 * stages and carries the ROB index and destination tag alongside.
 */
`timescale 1ns/10ps

module mult_pipe #(
	parameter int NUM_STAGES = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start_i,
	input  mult_pkg::issue_pkt_t  issue_pkt_i,
	output logic                  done_o,
	output mult_pkg::cdb_pkt_t    cdb_pkt_o
);

	localparam int SLICE_W = mult_pkg::XLEN / NUM_STAGES;

	logic [mult_pkg::XLEN-1:0] mcand;
	logic [mult_pkg::XLEN-1:0] mplier;
	logic [mult_pkg::XLEN-1:0] lit_ext;

	// element 0 feeds the first stage, element NUM_STAGES is the last output
	logic [NUM_STAGES:0][mult_pkg::XLEN-1:0] product_c;
	logic [NUM_STAGES:0][mult_pkg::XLEN-1:0] mplier_c;
	logic [NUM_STAGES:0][mult_pkg::XLEN-1:0] mcand_c;
	logic [NUM_STAGES:0]                     done_c;

	logic [NUM_STAGES-1:0][mult_pkg::ROB_IDX_W-1:0] rob_idx_r;
	logic [NUM_STAGES-1:0][mult_pkg::PRF_IDX_W-1:0] dest_tag_r;

	// literal form swaps opb for the zero-extended lit8
	assign lit_ext = {{(mult_pkg::XLEN-8){1'b0}}, issue_pkt_i.inst.l.lit8};
	assign mcand   = issue_pkt_i.opa;
	assign mplier  = issue_pkt_i.inst.r.lit_flag ? lit_ext : issue_pkt_i.opb;

	assign product_c[0] = '0;
	assign mplier_c[0]  = mplier;
	assign mcand_c[0]   = mcand;
	assign done_c[0]    = start_i;

	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		mult_stage #(
			.SLICE_W(SLICE_W)
		) mult_stage_i (
			.clock    (clock),
			.reset    (reset),
			.start_i  (done_c[s]),
			.product_i(product_c[s]),
			.mplier_i (mplier_c[s]),
			.mcand_i  (mcand_c[s]),
			.done_o   (done_c[s+1]),
			.product_o(product_c[s+1]),
			.mplier_o (mplier_c[s+1]),
			.mcand_o  (mcand_c[s+1])
		);
	end

	// the pipe never stalls, so the tags shift every cycle in step with done
	always_ff @(posedge clock) begin
		rob_idx_r[0]  <= issue_pkt_i.rob_idx;
		dest_tag_r[0] <= issue_pkt_i.dest_tag;
		for (int i = 1; i < NUM_STAGES; i++) begin
			rob_idx_r[i]  <= rob_idx_r[i-1];
			dest_tag_r[i] <= dest_tag_r[i-1];
		end
	end

	assign done_o             = done_c[NUM_STAGES];
	assign cdb_pkt_o.result   = product_c[NUM_STAGES];
	assign cdb_pkt_o.rob_idx  = rob_idx_r[NUM_STAGES-1];
	assign cdb_pkt_o.dest_tag = dest_tag_r[NUM_STAGES-1];

endmodule

// File: logic/cdb_result_queue.sv
/*
 * Result FIFO in front of the common data bus.
 * Credits cover results in flight and results stored, so the pipe can
 * always write and issue_ready_o drops once every slot is promised.
 */
`timescale 1ns/10ps

module cdb_result_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               issue_valid_i,
	output logic               issue_ready_o,
	output logic               accept_o,
	input  logic               wr_valid_i,
	input  mult_pkg::cdb_pkt_t wr_pkt_i,
	output logic               cdb_valid_o,
	output mult_pkg::cdb_pkt_t cdb_pkt_o,
	input  logic               cdb_ready_i
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(QUEUE_DEPTH);

	mult_pkg::cdb_pkt_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_ptr_next;
	logic [CNT_W-1:0] credits;
	logic             nonempty_r;
	logic             pop;

	// ready comes from registered state only
	assign issue_ready_o = (credits != MAX_CREDITS);
	assign accept_o      = issue_valid_i & issue_ready_o;

	assign cdb_valid_o = nonempty_r;
	assign cdb_pkt_o   = mem[rd_ptr];
	assign pop         = nonempty_r & cdb_ready_i;

	assign rd_ptr_next = (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

	always_ff @(posedge clock) begin
		if (wr_valid_i) begin
			mem[wr_ptr] <= wr_pkt_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			nonempty_r <= 1'b0;
		end else begin
			if (wr_valid_i) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr_next;
			end
			// a pop with no write empties the queue when read meets write
			if (wr_valid_i) begin
				nonempty_r <= 1'b1;
			end else if (pop) begin
				nonempty_r <= (rd_ptr_next != wr_ptr);
			end
		end
	end

	// credit taken on accept, returned on pop
	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= '0;
		end else begin
			case ({accept_o, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: logic/mult_unit.sv
/*
 * Integer multiply functional unit, top level.
 * Takes issued multiplies on a valid/ready port and returns results in
 * issue order on the CDB; NUM_STAGES and QUEUE_DEPTH are set here.
 */
`timescale 1ns/10ps

module mult_unit #(
	parameter int NUM_STAGES  = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_valid_i,
	input  mult_pkg::issue_pkt_t issue_pkt_i,
	output logic                 issue_ready_o,
	output logic                 cdb_valid_o,
	output mult_pkg::cdb_pkt_t   cdb_pkt_o,
	input  logic                 cdb_ready_i
);

	logic               accept;
	logic               pipe_done;
	mult_pkg::cdb_pkt_t pipe_pkt;

	mult_pipe #(
		.NUM_STAGES(NUM_STAGES)
	) mult_pipe_i (
		.clock      (clock),
		.reset      (reset),
		.start_i    (accept),
		.issue_pkt_i(issue_pkt_i),
		.done_o     (pipe_done),
		.cdb_pkt_o  (pipe_pkt)
	);

	// the queue grants issue and buffers results for the bus
	cdb_result_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) cdb_result_queue_i (
		.clock        (clock),
		.reset        (reset),
		.issue_valid_i(issue_valid_i),
		.issue_ready_o(issue_ready_o),
		.accept_o     (accept),
		.wr_valid_i   (pipe_done),
		.wr_pkt_i     (pipe_pkt),
		.cdb_valid_o  (cdb_valid_o),
		.cdb_pkt_o    (cdb_pkt_o),
		.cdb_ready_i  (cdb_ready_i)
	);

endmodule

// File: dv/mult_unit_tb.sv
/*
 * Testbench for the integer multiply unit.
 * Reads multiplies and expected products from the stimulus file, fills the
 * result queue under held back-pressure, then drains it under random CDB ready.
 */
`timescale 1ns/10ps

module mult_unit_tb;

	// must match the DUT defaults
	localparam int NUM_STAGES    = 4;
	localparam int QUEUE_DEPTH   = 4;
	localparam int ISSUE_TIMEOUT = 200;
	localparam int POP_TIMEOUT   = 500;
	localparam int HOLD_CYCLES   = 12;

	logic                 clock;
	logic                 reset;
	logic                 issue_valid_i;
	mult_pkg::issue_pkt_t issue_pkt_i;
	logic                 issue_ready_o;
	logic                 cdb_valid_o;
	mult_pkg::cdb_pkt_t   cdb_pkt_o;
	logic                 cdb_ready_i;

	mult_pkg::issue_pkt_t stim_q[$];
	logic [63:0]          prod_q[$];
	mult_pkg::cdb_pkt_t   expected_q[$];
	int                   popped;
	int unsigned          seed_val;

	mult_unit mult_unit_i (
		.clock        (clock),
		.reset        (reset),
		.issue_valid_i(issue_valid_i),
		.issue_pkt_i  (issue_pkt_i),
		.issue_ready_o(issue_ready_o),
		.cdb_valid_o  (cdb_valid_o),
		.cdb_pkt_o    (cdb_pkt_o),
		.cdb_ready_i  (cdb_ready_i)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h got %h", $time, what, expected, actual);
			report_failure("value mismatch");
		end
	endtask

	task automatic load_stimulus();
		int                   fd;
		int                   n;
		string                line;
		logic [63:0]          opa;
		logic [63:0]          opb;
		logic [31:0]          inst;
		logic [4:0]           rob;
		logic [5:0]           dest;
		logic [63:0]          prod;
		mult_pkg::issue_pkt_t pkt;
		fd = $fopen("dv/mult_stimulus.txt", "r");
		if (fd == 0) begin
			report_failure("could not open dv/mult_stimulus.txt");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// blank lines and lines starting with # carry no multiply
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h", opa, opb, inst, rob, dest, prod);
				if (n != 6) begin
					report_failure("malformed line in the stimulus file");
				end
				pkt.opa      = opa;
				pkt.opb      = opb;
				pkt.inst     = inst;
				pkt.rob_idx  = rob;
				pkt.dest_tag = dest;
				stim_q.push_back(pkt);
				prod_q.push_back(prod);
			end
		end
		$fclose(fd);
		if (stim_q.size() <= QUEUE_DEPTH) begin
			report_failure("stimulus file holds too few multiplies");
		end
	endtask

	// presents one packet and returns once the DUT takes it at the next edge
	task automatic issue_one(input int idx, output int waited);
		int                 cycles;
		mult_pkg::cdb_pkt_t exp_pkt;
		cycles = 0;
		@(posedge clock);
		issue_valid_i <= 1'b1;
		issue_pkt_i   <= stim_q[idx];
		@(negedge clock);
		while (!issue_ready_o) begin
			cycles++;
			if (cycles > ISSUE_TIMEOUT) begin
				report_failure("timeout while waiting for issue_ready_o");
			end
			@(negedge clock);
		end
		exp_pkt.result   = prod_q[idx];
		exp_pkt.rob_idx  = stim_q[idx].rob_idx;
		exp_pkt.dest_tag = stim_q[idx].dest_tag;
		expected_q.push_back(exp_pkt);
		waited = cycles;
	endtask

	task automatic issue_rest();
		int gap;
		int waited;
		for (int i = QUEUE_DEPTH; i < stim_q.size(); i++) begin
			gap = int'($urandom % 4);
			for (int g = 0; g < gap; g++) begin
				@(posedge clock);
				issue_valid_i <= 1'b0;
			end
			issue_one(i, waited);
		end
		@(posedge clock);
		issue_valid_i <= 1'b0;
	endtask

	task automatic collect_results(input int total);
		int                 idle;
		mult_pkg::cdb_pkt_t exp_pkt;
		idle = 0;
		while (popped < total) begin
			@(posedge clock);
			cdb_ready_i <= (($urandom % 4) != 32'd0);
			@(negedge clock);
			if (cdb_valid_o && cdb_ready_i) begin
				if (expected_q.size() == 0) begin
					report_failure("a result left the CDB with no multiply outstanding");
				end
				exp_pkt = expected_q.pop_front();
				check_equal(128'(cdb_pkt_o.result), 128'(exp_pkt.result), "result");
				check_equal(128'(cdb_pkt_o.rob_idx), 128'(exp_pkt.rob_idx), "rob_idx");
				check_equal(128'(cdb_pkt_o.dest_tag), 128'(exp_pkt.dest_tag), "dest_tag");
				popped++;
				idle = 0;
			end else begin
				idle++;
				if (idle > POP_TIMEOUT) begin
					report_failure("timeout while waiting for a result on the CDB");
				end
			end
		end
	endtask

	initial begin
		int                 waited;
		int                 cycles;
		mult_pkg::cdb_pkt_t head;
		reset         = 1'b1;
		issue_valid_i = 1'b0;
		issue_pkt_i   = '0;
		cdb_ready_i   = 1'b0;
		popped        = 0;
		seed_val      = $urandom(32'hd80b0f87);
		load_stimulus();

		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_equal(128'(cdb_valid_o), 128'(1'b0), "cdb_valid_o after reset");
		check_equal(128'(issue_ready_o), 128'(1'b1), "issue_ready_o after reset");

		// fill every credit with the bus stalled
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			issue_one(i, waited);
			check_equal(128'(waited), 128'(0), "stall before queue full");
		end
		@(posedge clock);
		issue_valid_i <= 1'b0;
		@(negedge clock);
		check_equal(128'(issue_ready_o), 128'(1'b0), "issue_ready_o with all credits used");

		cycles = 0;
		while (!cdb_valid_o) begin
			cycles++;
			if (cycles > NUM_STAGES + 20) begin
				report_failure("timeout while waiting for the first result");
			end
			@(negedge clock);
		end
		head = cdb_pkt_o;
		check_equal(128'(head), 128'(expected_q[0]), "head result under back-pressure");
		// head must hold while the bus is not ready
		repeat (HOLD_CYCLES) begin
			@(negedge clock);
			check_equal(128'(cdb_valid_o), 128'(1'b1), "cdb_valid_o while held");
			check_equal(128'(cdb_pkt_o), 128'(head), "held cdb_pkt_o");
			check_equal(128'(issue_ready_o), 128'(1'b0), "issue_ready_o while held");
		end

		fork
			issue_rest();
			collect_results(stim_q.size());
		join

		// no extra result follows the last one and every credit is returned
		repeat (NUM_STAGES + 2) begin
			@(negedge clock);
			check_equal(128'(cdb_valid_o), 128'(1'b0), "cdb_valid_o after the last result");
		end
		check_equal(128'(issue_ready_o), 128'(1'b1), "issue_ready_o after the last result");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: dv/mult_stimulus.txt
# opa opb inst rob_idx dest_tag expected, all hex
# inst bit 12 set means the literal in bits 20:13 replaces opb
0000000000000003 0000000000000005 4c220403 00 01 000000000000000f
0000000000000007 0000000000000009 4c220403 01 02 000000000000003f
0000000000000000 123456789abcdef0 4c220403 02 03 0000000000000000
ffffffffffffffff ffffffffffffffff 4c220403 03 04 0000000000000001
ffffffffffffffff 0000000000000002 4c220403 04 05 fffffffffffffffe
ffffffffffffffff 0000000000000001 4c220403 05 06 ffffffffffffffff
000000000000ffff 000000000000ffff 4c220403 06 07 00000000fffe0001
00000000ffffffff 00000000ffffffff 4c220403 07 08 fffffffe00000001
0000000100000000 0000000100000000 4c220403 08 09 0000000000000000
0000000080000000 0000000080000000 4c220403 09 0a 4000000000000000
0000000000000007 00000000deadbeef 4c20b403 0a 0b 0000000000000023
123456789abcdef0 0000000000000001 4c220403 0b 0c 123456789abcdef0
123456789abcdef0 0000000000000010 4c220403 0c 0d 23456789abcdef00
1111111111111111 000000000000000f 4c220403 0d 0e ffffffffffffffff
0101010101010101 00000000000000ff 4c220403 0e 0f ffffffffffffffff
0101010101010101 1234000000000000 4c3ff403 0f 10 ffffffffffffffff
ffffffffffffffff 0000000000000007 4c3ff403 10 11 ffffffffffffff01
123456789abcdef0 ffffffffffffffff 4c201403 11 12 0000000000000000
123456789abcdef0 5555555555555555 4c203403 12 13 123456789abcdef0
0000000000010001 000000000000ffff 4c220403 13 14 00000000ffffffff
ffffffffffffffff 0000000000010000 4c220403 14 15 ffffffffffff0000
8000000000000000 0000000000000002 4c220403 15 16 0000000000000000
8000000000000000 0000000000000003 4c220403 16 17 8000000000000000
0000000000001000 0000000000001000 4c220403 17 18 0000000001000000
00000000ffff0000 0000000000010001 4c220403 18 19 0000ffffffff0000
fedcba9876543210 0000000000000003 4c221403 19 1a edcba98765432100
8000000000000000 0000000000000001 4c205403 1a 1b 0000000000000000
0000000000000002 aaaaaaaaaaaaaaaa 4c301403 1b 1c 0000000000000100
5555555555555555 0000000000000009 4c207403 1c 1d ffffffffffffffff
0123456789abcdef 0000000000000100 4c220403 1d 1e 23456789abcdef00
fedcba9876543210 0000000000000010 4c220403 1e 1f edcba98765432100
0000000000000002 8000000000000000 4c220403 1f 20 0000000000000000
00000000000000ff 00000000000000ff 4c220403 00 21 000000000000fe01
000000000000ffff 0000000000010001 4c220403 01 22 00000000ffffffff
7fffffffffffffff 0000000000000002 4c220403 02 23 fffffffffffffffe
7fffffffffffffff 7fffffffffffffff 4c220403 03 24 0000000000000001
ffffffff00000000 ffffffff00000000 4c220403 04 25 0000000000000000
00000000ffffffff 0000000100000001 4c220403 05 26 ffffffffffffffff
0000000000000005 fffffffffffffffb 4c220403 06 27 ffffffffffffffe7
fffffffffffffffe fffffffffffffffe 4c220403 07 28 0000000000000004
0000000000000010 0000000000000010 4c220403 08 29 0000000000000100
1111111111111111 0000000000000002 4c21f403 09 2a ffffffffffffffff
0f0f0f0f0f0f0f0f ffffffffffffffff 4c223403 0a 2b ffffffffffffffff
4000000000000000 0000000000000001 4c209403 0b 2c 0000000000000000
0000000000000003 0000000000000004 4c281403 0c 2d 00000000000000c0
00000000000000ff 0000000000000005 4c241403 0d 2e 0000000000001fe0
0000000000000007 0000000000000009 4c220403 0e 2f 000000000000003f
ffffffffffffffff ffffffffffffffff 4c220403 0f 30 0000000000000001
000000000000ffff 000000000000ffff 4c220403 10 31 00000000fffe0001
0000000000000007 0000000000000001 4c20b403 11 32 0000000000000023
00000000ffffffff 00000000ffffffff 4c220403 12 33 fffffffe00000001
123456789abcdef0 ffffffffffffffff 4c201403 13 34 0000000000000000
0000000000000003 0000000000000005 4c220403 14 35 000000000000000f
0101010101010101 0000000000000000 4c3ff403 15 36 ffffffffffffffff

// File: files.f
logic/mult_pkg.sv
logic/mult_stage.sv
logic/mult_pipe.sv
logic/cdb_result_queue.sv
logic/mult_unit.sv
dv/mult_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the multiply unit testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module mult_unit_tb \
	-Mdir obj_dir -o mult_unit_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/mult_unit_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi
